// File: sources.f
vchan_pkg.sv
vchan_mux.sv
vchan_demux.sv
vchan_demux_tree.sv
vchan_switch_top.sv
tb_vchan_switch.sv

// File: Bender.yml
package:
  name: vchan_switch

sources:
  - vchan_pkg.sv
  - vchan_mux.sv
  - vchan_demux.sv
  - vchan_demux_tree.sv
  - vchan_switch_top.sv
  - target: test
    files:
      - tb_vchan_switch.sv

// File: tb_vchan_switch.sv
`timescale 1ns/1ps

module tb_vchan_switch;

    // ========================================================================
    // Run constants
    // ========================================================================

    localparam int NP = vchan_pkg::NUM_PORTS;
    localparam int DW = vchan_pkg::DATA_WIDTH;
    localparam int PW = vchan_pkg::PORT_SEL_WIDTH;

    // Random packets per source, then a few back-to-back packets for fairness
    localparam int NUM_PKTS  = 40;
    localparam int FAIR_PKTS = 2;
    localparam int MAX_LEN   = 4;
    localparam int MAX_BEATS = (NUM_PKTS + FAIR_PKTS) * MAX_LEN;
    // Worst case beat count over all lanes, ten cycles each for stalls and gaps
    localparam int CYCLE_LIMIT = 10 * NP * MAX_BEATS;

    integer seed;

    logic                   clk;
    logic                   rst_n;
    logic [NP-1:0]          src_valid;
    logic [NP-1:0]          src_ready;
    logic [NP-1:0][DW-1:0]  src_data;
    logic [NP-1:0][PW-1:0]  src_dest;
    logic [NP-1:0]          src_last;
    logic [NP-1:0]          dst_valid;
    logic [NP-1:0]          dst_ready;
    logic [NP-1:0][DW-1:0]  dst_data;
    logic [NP-1:0][PW-1:0]  dst_src;
    logic [NP-1:0]          dst_last;

    // Pre-built traffic per source lane
    logic [DW-1:0] gen_data [NP][MAX_BEATS];
    logic [PW-1:0] gen_dest [NP][MAX_BEATS];
    logic          gen_last [NP][MAX_BEATS];
    int            rand_beats [NP];
    int            total_beats [NP];
    int            next_beat [NP];

    // Scoreboard, one FIFO per source and destination pair
    logic [DW-1:0] sb_data [NP*NP][MAX_BEATS];
    logic          sb_last [NP*NP][MAX_BEATS];
    logic          sb_fair [NP*NP][MAX_BEATS];
    int            sb_wr [NP*NP];
    int            sb_rd [NP*NP];

    // Packet tracking per destination
    logic          in_pkt [NP];
    logic [PW-1:0] pkt_src [NP];

    logic          fair_phase;
    logic          fair_seen;
    logic [PW-1:0] last_fair_src;
    logic          run_done;
    logic          timed_out;
    int            outstanding;
    int            cyc;
    int            err_data;
    int            err_port;
    int            err_last;
    int            err_other;

    vchan_switch_top i_dut (
        .clk       (clk),
        .rst_n     (rst_n),
        .src_valid (src_valid),
        .src_ready (src_ready),
        .src_data  (src_data),
        .src_dest  (src_dest),
        .src_last  (src_last),
        .dst_valid (dst_valid),
        .dst_ready (dst_ready),
        .dst_data  (dst_data),
        .dst_src   (dst_src),
        .dst_last  (dst_last)
    );

    always #50 clk = ~clk;

    // ========================================================================
    // Compare tasks
    // ========================================================================

    task automatic check_data(input string name, input logic [DW-1:0] exp_val,
                              input logic [DW-1:0] act_val);
        if (act_val !== exp_val) begin
            err_data++;
            $display("error %s: expected %h, actual %h", name, exp_val, act_val);
        end
    endtask

    task automatic check_port(input string name, input logic [PW-1:0] exp_val,
                              input logic [PW-1:0] act_val);
        if (act_val !== exp_val) begin
            err_port++;
            $display("error %s: expected %0d, actual %0d", name, exp_val, act_val);
        end
    endtask

    task automatic check_last(input string name, input logic exp_val, input logic act_val);
        if (act_val !== exp_val) begin
            err_last++;
            $display("error %s: expected %b, actual %b", name, exp_val, act_val);
        end
    endtask

    task automatic check_reset(input string name);
        for (int i = 0; i < NP; i++) begin
            check_last($sformatf("%s dst_valid %0d", name, i), 1'b0, dst_valid[i]);
            check_last($sformatf("%s src_ready %0d", name, i), 1'b0, src_ready[i]);
        end
    endtask

    // ========================================================================
    // Traffic and scoreboard
    // ========================================================================

    // Random packets first, then the fairness packets all aimed at port 0
    task automatic gen_traffic();
        int            n;
        int            len;
        logic [PW-1:0] dest;
        for (int s = 0; s < NP; s++) begin
            n = 0;
            for (int p = 0; p < NUM_PKTS + FAIR_PKTS; p++) begin
                if (p == NUM_PKTS)
                    rand_beats[s] = n;
                len  = 1 + {$random(seed)} % MAX_LEN;
                dest = (p < NUM_PKTS) ? PW'({$random(seed)} % NP) : '0;
                for (int b = 0; b < len; b++) begin
                    gen_data[s][n] = $random(seed);
                    gen_dest[s][n] = dest;
                    gen_last[s][n] = (b == len - 1);
                    n++;
                end
            end
            total_beats[s] = n;
        end
    endtask

    function automatic logic lanes_finished();
        lanes_finished = 1'b1;
        for (int s = 0; s < NP; s++)
            if (next_beat[s] != total_beats[s])
                lanes_finished = 1'b0;
    endfunction

    task automatic record_accepts();
        int pair;
        for (int s = 0; s < NP; s++) begin
            if (src_valid[s] && src_ready[s]) begin
                pair = s * NP + int'(src_dest[s]);
                sb_data[pair][sb_wr[pair]] = src_data[s];
                sb_last[pair][sb_wr[pair]] = src_last[s];
                sb_fair[pair][sb_wr[pair]] = fair_phase;
                sb_wr[pair]++;
                next_beat[s]++;
                outstanding++;
            end
        end
    endtask

    task automatic check_outputs();
        int s;
        int pair;
        int rd;
        for (int d = 0; d < NP; d++) begin
            if (dst_valid[d] && dst_ready[d]) begin
                s = int'(dst_src[d]);
                pair = s * NP + d;
                if (s >= NP) begin
                    err_other++;
                    $display("destination %0d got a beat from unknown source %0d", d, s);
                end else if (sb_rd[pair] == sb_wr[pair]) begin
                    err_other++;
                    $display("destination %0d got an unexpected beat from source %0d", d, s);
                end else begin
                    rd = sb_rd[pair];
                    // Mid-packet beats must stay with the source that opened it
                    if (in_pkt[d]) begin
                        check_port($sformatf("atomicity dst %0d", d), pkt_src[d], dst_src[d]);
                    end else begin
                        pkt_src[d] = dst_src[d];
                        // Saturated sources take turns in index order
                        if (sb_fair[pair][rd]) begin
                            if (fair_seen)
                                check_port("fairness", PW'((int'(last_fair_src) + 1) % NP),
                                           dst_src[d]);
                            fair_seen     = 1'b1;
                            last_fair_src = dst_src[d];
                        end
                    end
                    in_pkt[d] = !dst_last[d];
                    check_data($sformatf("data src %0d dst %0d", s, d), sb_data[pair][rd],
                               dst_data[d]);
                    check_last($sformatf("last src %0d dst %0d", s, d), sb_last[pair][rd],
                               dst_last[d]);
                    sb_rd[pair]++;
                    outstanding--;
                end
            end
        end
    endtask

    task automatic drive_sources();
        int   idx;
        int   limit;
        logic all_done;
        // Fairness traffic starts on every lane at once
        if (!fair_phase) begin
            all_done = 1'b1;
            for (int s = 0; s < NP; s++)
                if (next_beat[s] != rand_beats[s])
                    all_done = 1'b0;
            fair_phase = all_done;
        end
        for (int s = 0; s < NP; s++) begin
            // A stalled beat stays put
            if (!(src_valid[s] && !src_ready[s])) begin
                idx   = next_beat[s];
                limit = fair_phase ? total_beats[s] : rand_beats[s];
                if (idx < limit && (fair_phase || ($random(seed) & 3) != 0)) begin
                    src_valid[s] <= 1'b1;
                    src_data[s]  <= gen_data[s][idx];
                    src_dest[s]  <= gen_dest[s][idx];
                    src_last[s]  <= gen_last[s][idx];
                end else begin
                    src_valid[s] <= 1'b0;
                end
            end
        end
    endtask

    // About 70 percent ready, port 0 never stalls while fairness runs
    task automatic drive_ready();
        for (int d = 0; d < NP; d++) begin
            if (fair_phase && d == 0)
                dst_ready[d] <= 1'b1;
            else
                dst_ready[d] <= ({$random(seed)} % 10) < 7;
        end
    endtask

    always @(posedge clk) begin
        cyc++;
        if (cyc >= CYCLE_LIMIT)
            timed_out = 1'b1;
        if (rst_n) begin
            record_accepts();
            check_outputs();
            drive_sources();
            drive_ready();
            if (lanes_finished() && outstanding == 0)
                run_done = 1'b1;
        end
    end

    // ========================================================================
    // Reset, run and report
    // ========================================================================

    initial begin
        seed          = 32'hefff08df;
        clk           = 1'b0;
        rst_n         = 1'b0;
        src_valid     = '0;
        src_data      = '0;
        src_dest      = '0;
        src_last      = '0;
        dst_ready     = '0;
        fair_phase    = 1'b0;
        fair_seen     = 1'b0;
        last_fair_src = '0;
        run_done      = 1'b0;
        timed_out     = 1'b0;
        outstanding   = 0;
        cyc           = 0;
        err_data      = 0;
        err_port      = 0;
        err_last      = 0;
        err_other     = 0;
        for (int i = 0; i < NP * NP; i++) begin
            sb_wr[i] = 0;
            sb_rd[i] = 0;
        end
        for (int i = 0; i < NP; i++) begin
            next_beat[i] = 0;
            in_pkt[i]    = 1'b0;
            pkt_src[i]   = '0;
        end
        gen_traffic();

        // Two reset edges, then release
        @(posedge clk);
        @(posedge clk);
        check_reset("reset held");
        rst_n <= 1'b1;
        // First edge out of reset, arbiter has not granted yet
        @(posedge clk);
        @(negedge clk);
        check_reset("after reset");

        wait (run_done || timed_out);
        // Final handshake has cleared the output slots by the falling edge
        @(negedge clk);
        if (timed_out && !run_done) begin
            err_other++;
            $display("run timed out after %0d cycles with %0d beats outstanding",
                     cyc, outstanding);
        end
        for (int p = 0; p < NP * NP; p++) begin
            if (sb_rd[p] != sb_wr[p]) begin
                err_other++;
                $display("source %0d to destination %0d left %0d beats undelivered",
                         p / NP, p % NP, sb_wr[p] - sb_rd[p]);
            end
        end
        if (dst_valid != '0) begin
            err_other++;
            $display("a destination still shows a beat after all traffic was delivered");
        end

        $display("errors: data %0d, port %0d, last %0d, other %0d",
                 err_data, err_port, err_last, err_other);
        if (err_data + err_port + err_last + err_other == 0)
            $display("** PASS **");
        else
            $display("** FAIL **");
        $finish;
    end

endmodule

// File: vchan_switch_top.sv
`timescale 1ns/1ps

module vchan_switch_top (
    input  logic                                                         clk,
    input  logic                                                         rst_n,
    input  logic [vchan_pkg::NUM_PORTS-1:0]                              src_valid,
    output logic [vchan_pkg::NUM_PORTS-1:0]                              src_ready,
    input  logic [vchan_pkg::NUM_PORTS-1:0][vchan_pkg::DATA_WIDTH-1:0]     src_data,
    input  logic [vchan_pkg::NUM_PORTS-1:0][vchan_pkg::PORT_SEL_WIDTH-1:0] src_dest,
    input  logic [vchan_pkg::NUM_PORTS-1:0]                              src_last,
    output logic [vchan_pkg::NUM_PORTS-1:0]                              dst_valid,
    input  logic [vchan_pkg::NUM_PORTS-1:0]                              dst_ready,
    output logic [vchan_pkg::NUM_PORTS-1:0][vchan_pkg::DATA_WIDTH-1:0]     dst_data,
    output logic [vchan_pkg::NUM_PORTS-1:0][vchan_pkg::PORT_SEL_WIDTH-1:0] dst_src,
    output logic [vchan_pkg::NUM_PORTS-1:0]                              dst_last
);

    // Multiplexed stream between arbiter and tree
    logic                             m_valid;
    logic                             m_ready;
    logic [vchan_pkg::DATA_WIDTH-1:0] m_data;
    logic [vchan_pkg::USER_WIDTH-1:0] m_user;
    logic                             m_last;

    logic [vchan_pkg::NUM_PORTS-1:0][vchan_pkg::USER_WIDTH-1:0] dst_user;

    vchan_mux u_mux (
        .clk       (clk),
        .rst_n     (rst_n),
        .src_valid (src_valid),
        .src_ready (src_ready),
        .src_data  (src_data),
        .src_dest  (src_dest),
        .src_last  (src_last),
        .m_valid   (m_valid),
        .m_ready   (m_ready),
        .m_data    (m_data),
        .m_user    (m_user),
        .m_last    (m_last)
    );

    // Full index range, decoded from bit 0 up
    vchan_demux_tree #(
        .NUM_DEMUX_PORTS (vchan_pkg::NUM_PORTS),
        .PORT_IDX_BASE   (0)
    ) u_tree (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (m_valid),
        .in_ready  (m_ready),
        .in_data   (m_data),
        .in_user   (m_user),
        .in_last   (m_last),
        .out_valid (dst_valid),
        .out_ready (dst_ready),
        .out_data  (dst_data),
        .out_user  (dst_user),
        .out_last  (dst_last)
    );

    for (genvar i = 0; i < vchan_pkg::NUM_PORTS; i++) begin : g_dst
        // Source index from the high half of the tag
        assign dst_src[i] = dst_user[i][vchan_pkg::USER_WIDTH-1 -: vchan_pkg::PORT_SEL_WIDTH];

        // Tag from the arbiter must land on the port it names
        a_route: assert property (@(posedge clk) disable iff (!rst_n)
            dst_valid[i] |-> dst_user[i][vchan_pkg::PORT_SEL_WIDTH-1:0] == i);
    end

endmodule

// File: vchan_demux_tree.sv
`timescale 1ns/1ps

module vchan_demux_tree #(
    parameter int NUM_DEMUX_PORTS = 2,
    parameter int PORT_IDX_BASE   = 0
) (
    input  logic                                                clk,
    input  logic                                                rst_n,
    input  logic                                                in_valid,
    output logic                                                in_ready,
    input  logic [vchan_pkg::DATA_WIDTH-1:0]                    in_data,
    input  logic [vchan_pkg::USER_WIDTH-1:0]                    in_user,
    input  logic                                                in_last,
    output logic [NUM_DEMUX_PORTS-1:0]                          out_valid,
    input  logic [NUM_DEMUX_PORTS-1:0]                          out_ready,
    output logic [NUM_DEMUX_PORTS-1:0][vchan_pkg::DATA_WIDTH-1:0] out_data,
    output logic [NUM_DEMUX_PORTS-1:0][vchan_pkg::USER_WIDTH-1:0] out_user,
    output logic [NUM_DEMUX_PORTS-1:0]                          out_last
);

    if (NUM_DEMUX_PORTS <= vchan_pkg::PORTS_PER_LEVEL) begin : g_leaf

        // Small enough for one node, decode the low index bits
        vchan_demux #(
            .NUM_DEMUX_PORTS    (NUM_DEMUX_PORTS),
            .PORT_IDX_START_BIT (PORT_IDX_BASE)
        ) u_demux (
            .clk       (clk),
            .rst_n     (rst_n),
            .in_valid  (in_valid),
            .in_ready  (in_ready),
            .in_data   (in_data),
            .in_user   (in_user),
            .in_last   (in_last),
            .out_valid (out_valid),
            .out_ready (out_ready),
            .out_data  (out_data),
            .out_user  (out_user),
            .out_last  (out_last)
        );

    end else begin : g_tree

        // ====================================================================
        // Upper node plus one subtree per cluster
        // ====================================================================

        localparam int SEL_WIDTH = $clog2(NUM_DEMUX_PORTS);
        // Top index bits pick the cluster
        localparam int TREE_IDX_START = PORT_IDX_BASE + SEL_WIDTH - vchan_pkg::TREE_IDX_WIDTH;
        // Outputs per cluster, a power of two
        localparam int CHILD_PORTS = 1 << (SEL_WIDTH - vchan_pkg::TREE_IDX_WIDTH);
        localparam int NUM_TREE_PORTS = (NUM_DEMUX_PORTS + CHILD_PORTS - 1) / CHILD_PORTS;

        logic [NUM_TREE_PORTS-1:0]                          t_valid;
        logic [NUM_TREE_PORTS-1:0]                          t_ready;
        logic [NUM_TREE_PORTS-1:0][vchan_pkg::DATA_WIDTH-1:0] t_data;
        logic [NUM_TREE_PORTS-1:0][vchan_pkg::USER_WIDTH-1:0] t_user;
        logic [NUM_TREE_PORTS-1:0]                          t_last;

        vchan_demux #(
            .NUM_DEMUX_PORTS    (NUM_TREE_PORTS),
            .PORT_IDX_START_BIT (TREE_IDX_START)
        ) u_upper (
            .clk       (clk),
            .rst_n     (rst_n),
            .in_valid  (in_valid),
            .in_ready  (in_ready),
            .in_data   (in_data),
            .in_user   (in_user),
            .in_last   (in_last),
            .out_valid (t_valid),
            .out_ready (t_ready),
            .out_data  (t_data),
            .out_user  (t_user),
            .out_last  (t_last)
        );

        for (genvar i = 0; i < NUM_TREE_PORTS; i++) begin : g_child
            // Last cluster takes whatever is left
            localparam int ITER_PORTS = (i == NUM_TREE_PORTS - 1) ?
                                        NUM_DEMUX_PORTS - i * CHILD_PORTS : CHILD_PORTS;

            // Low bits keep the same base, cluster offset lives in the high bits
            vchan_demux_tree #(
                .NUM_DEMUX_PORTS (ITER_PORTS),
                .PORT_IDX_BASE   (PORT_IDX_BASE)
            ) u_node (
                .clk       (clk),
                .rst_n     (rst_n),
                .in_valid  (t_valid[i]),
                .in_ready  (t_ready[i]),
                .in_data   (t_data[i]),
                .in_user   (t_user[i]),
                .in_last   (t_last[i]),
                .out_valid (out_valid[i*CHILD_PORTS +: ITER_PORTS]),
                .out_ready (out_ready[i*CHILD_PORTS +: ITER_PORTS]),
                .out_data  (out_data[i*CHILD_PORTS +: ITER_PORTS]),
                .out_user  (out_user[i*CHILD_PORTS +: ITER_PORTS]),
                .out_last  (out_last[i*CHILD_PORTS +: ITER_PORTS])
            );
        end

    end

endmodule

// File: vchan_demux.sv
`timescale 1ns/1ps

module vchan_demux #(
    parameter int NUM_DEMUX_PORTS    = 2,
    parameter int PORT_IDX_START_BIT = 0
) (
    input  logic                                                clk,
    input  logic                                                rst_n,
    input  logic                                                in_valid,
    output logic                                                in_ready,
    input  logic [vchan_pkg::DATA_WIDTH-1:0]                    in_data,
    input  logic [vchan_pkg::USER_WIDTH-1:0]                    in_user,
    input  logic                                                in_last,
    output logic [NUM_DEMUX_PORTS-1:0]                          out_valid,
    input  logic [NUM_DEMUX_PORTS-1:0]                          out_ready,
    output logic [NUM_DEMUX_PORTS-1:0][vchan_pkg::DATA_WIDTH-1:0] out_data,
    output logic [NUM_DEMUX_PORTS-1:0][vchan_pkg::USER_WIDTH-1:0] out_user,
    output logic [NUM_DEMUX_PORTS-1:0]                          out_last
);

    // One-port node still reads a single index bit
    localparam int SEL_WIDTH = (NUM_DEMUX_PORTS > 1) ? $clog2(NUM_DEMUX_PORTS) : 1;

    logic [SEL_WIDTH-1:0]       sel;
    logic [NUM_DEMUX_PORTS-1:0] slot_free;
    logic                       accept;

    // Slice of the destination half of the tag
    assign sel    = in_user[PORT_IDX_START_BIT +: SEL_WIDTH];
    assign accept = in_valid && in_ready;

    // ========================================================================
    // Input acceptance
    // ========================================================================

    always_comb begin
        in_ready = 1'b0;
        for (int i = 0; i < NUM_DEMUX_PORTS; i++) begin
            slot_free[i] = !out_valid[i] || out_ready[i];
            // Out of range index never gets ready
            if (sel == SEL_WIDTH'(i))
                in_ready = slot_free[i];
        end
    end

    // ========================================================================
    // Per-output slots
    // ========================================================================

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            out_valid <= '0;
        end else begin
            for (int i = 0; i < NUM_DEMUX_PORTS; i++) begin
                if (accept && sel == SEL_WIDTH'(i))
                    out_valid[i] <= 1'b1;
                else if (out_ready[i])
                    out_valid[i] <= 1'b0;
            end
        end
    end

    // Tag passes through untouched for the nodes below
    always_ff @(posedge clk) begin
        for (int i = 0; i < NUM_DEMUX_PORTS; i++) begin
            if (accept && sel == SEL_WIDTH'(i)) begin
                out_data[i] <= in_data;
                out_user[i] <= in_user;
                out_last[i] <= in_last;
            end
        end
    end

    // Upstream tag must select an existing output of this node
    a_sel_range: assert property (@(posedge clk) disable iff (!rst_n)
        in_valid |-> sel < NUM_DEMUX_PORTS);

endmodule

// File: vchan_mux.sv
`timescale 1ns/1ps

module vchan_mux (
    input  logic                                                         clk,
    input  logic                                                         rst_n,
    input  logic [vchan_pkg::NUM_PORTS-1:0]                              src_valid,
    output logic [vchan_pkg::NUM_PORTS-1:0]                              src_ready,
    input  logic [vchan_pkg::NUM_PORTS-1:0][vchan_pkg::DATA_WIDTH-1:0]     src_data,
    input  logic [vchan_pkg::NUM_PORTS-1:0][vchan_pkg::PORT_SEL_WIDTH-1:0] src_dest,
    input  logic [vchan_pkg::NUM_PORTS-1:0]                              src_last,
    output logic                                                         m_valid,
    input  logic                                                         m_ready,
    output logic [vchan_pkg::DATA_WIDTH-1:0]                             m_data,
    output logic [vchan_pkg::USER_WIDTH-1:0]                             m_user,
    output logic                                                         m_last
);

    vchan_pkg::arb_state_e state;

    // Granted source while locked
    logic [vchan_pkg::PORT_SEL_WIDTH-1:0] gnt_idx;
    // Highest priority source for the next pick
    logic [vchan_pkg::PORT_SEL_WIDTH-1:0] rr_ptr;
    logic [vchan_pkg::PORT_SEL_WIDTH-1:0] pick_idx;
    logic                                 pick_found;

    // Output slot empty or draining this cycle
    logic out_free;
    logic accept;

    assign out_free = !m_valid || m_ready;
    assign accept   = (state == vchan_pkg::ARB_LOCKED) && src_valid[gnt_idx] && out_free;

    // ========================================================================
    // Round-robin pick
    // ========================================================================

    // Scan from the farthest offset down so the nearest requester wins
    always_comb begin
        int idx;
        pick_found = 1'b0;
        pick_idx   = rr_ptr;
        for (int off = vchan_pkg::NUM_PORTS - 1; off >= 0; off--) begin
            idx = (int'(rr_ptr) + off) % vchan_pkg::NUM_PORTS;
            if (src_valid[idx]) begin
                pick_found = 1'b1;
                pick_idx   = vchan_pkg::PORT_SEL_WIDTH'(idx);
            end
        end
    end

    // ========================================================================
    // Grant FSM
    // ========================================================================

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state   <= vchan_pkg::ARB_IDLE;
            gnt_idx <= '0;
            rr_ptr  <= '0;
        end else begin
            case (state)
                vchan_pkg::ARB_IDLE: begin
                    if (pick_found) begin
                        gnt_idx <= pick_idx;
                        // Winner drops to lowest priority
                        if (pick_idx == vchan_pkg::PORT_SEL_WIDTH'(vchan_pkg::NUM_PORTS - 1))
                            rr_ptr <= '0;
                        else
                            rr_ptr <= pick_idx + 1'b1;
                        state <= vchan_pkg::ARB_LOCKED;
                    end
                end
                vchan_pkg::ARB_LOCKED: begin
                    // Release only at the end of the packet
                    if (accept && src_last[gnt_idx])
                        state <= vchan_pkg::ARB_IDLE;
                end
                default: state <= vchan_pkg::ARB_IDLE;
            endcase
        end
    end

    // Ready goes to the granted lane only
    always_comb begin
        src_ready = '0;
        if (state == vchan_pkg::ARB_LOCKED && out_free)
            src_ready[gnt_idx] = 1'b1;
    end

    // ========================================================================
    // Output register
    // ========================================================================

    always_ff @(posedge clk) begin
        if (!rst_n)
            m_valid <= 1'b0;
        else if (accept)
            m_valid <= 1'b1;
        else if (m_ready)
            m_valid <= 1'b0;
    end

    // Tag carries source in the high half, destination in the low half
    always_ff @(posedge clk) begin
        if (accept) begin
            m_data <= src_data[gnt_idx];
            m_user <= {gnt_idx, src_dest[gnt_idx]};
            m_last <= src_last[gnt_idx];
        end
    end

    // Grant is exclusive
    a_one_ready: assert property (@(posedge clk) disable iff (!rst_n)
        $onehot0(src_ready));

    // Stalled output holds its payload
    a_hold: assert property (@(posedge clk) disable iff (!rst_n)
        m_valid && !m_ready |=> m_valid && $stable(m_data) && $stable(m_user)
                                && $stable(m_last));

    // Sources only name existing destinations
    a_dest_range: assert property (@(posedge clk) disable iff (!rst_n)
        accept |-> src_dest[gnt_idx] < vchan_pkg::NUM_PORTS);

endmodule

// File: vchan_pkg.sv
package vchan_pkg;

    // ========================================================================
    // Port counts and widths
    // ========================================================================

    // Source ports and destination ports, same count on both sides
    localparam int NUM_PORTS = 12;

    // Payload word
    localparam int DATA_WIDTH = 32;

    // Port index, wide enough for NUM_PORTS
    localparam int PORT_SEL_WIDTH = 4;

    // User tag layout
    // High half holds the source index, low half the destination index
    localparam int USER_WIDTH = 2 * PORT_SEL_WIDTH;

    // ========================================================================
    // Demux tree shape
    // ========================================================================

    // Widest fan-out allowed in a single demux node
    localparam int PORTS_PER_LEVEL = 4;

    // Destination index bits consumed by an upper tree node
    localparam int TREE_IDX_WIDTH = $clog2(PORTS_PER_LEVEL);

    // ========================================================================
    // Arbiter
    // ========================================================================

    // ARB_IDLE: no packet in flight
    // ARB_LOCKED: grant held until the last beat is accepted
    typedef enum logic {
        ARB_IDLE,
        ARB_LOCKED
    } arb_state_e;

endpackage
